// ==== flist.f ====
rtl/ubaBusPkg.sv
rtl/ubaRegPkg.sv
rtl/ubaRegs.sv
rtl/ubaNxd.sv
rtl/ubaResp.sv
rtl/ubaTop.sv
tests/ubaTb.sv

// ==== rtl/ubaBusPkg.sv ====
/*
 Bus side definitions for the Unibus adapter slave front end.
 Holds the master request, the external device answer and the
 adapter response, plus the IO page and register window addresses.
 Import wherever a module touches the bus structs.
*/

package ubaBusPkg;

   ////////////////////////////////////////
   // Address map
   ////////////////////////////////////////

   // Top 8 KB of the 18-bit Unibus space
   localparam logic [17:0] ioPageBase = 18'o760000;

   // Adapter register window, two words at byte offsets 0 and 2
   localparam logic [17:0] regWinBase = 18'o763100;

   // Counting states before a non-existent device timeout
   localparam int nxdCount = 10;
   localparam int nxdCntW  = $clog2(nxdCount);

   ////////////////////////////////////////
   // Bus structs
   ////////////////////////////////////////

   // Master request, valid is a level held until answered
   typedef struct packed {
      logic        valid;
      logic        write;
      logic [17:0] addr;
      logic [15:0] wdata;
   } ubaReq_t;

   // External device answer, ack is a single cycle pulse
   typedef struct packed {
      logic        ack;
      logic [15:0] rdata;
   } ubaDevRsp_t;

   // Adapter answer to the master
   typedef struct packed {
      logic        ack;     // level, held while valid is high
      logic        nxd;     // one cycle timeout pulse
      logic [15:0] rdata;
   } ubaResp_t;

endpackage

// ==== rtl/ubaNxd.sv ====
/*
 Non-existent device state machine. Acknowledges register window
 hits on the next clock, waits for an external device ack on other
 IO page addresses and flags a timeout after the counting states
 run out. Addresses outside the IO page are ignored.
*/

`timescale 1ns/1ps

module ubaNxd
   import ubaBusPkg::*;
(
   input  logic    clk,
   input  logic    rst,
   input  ubaReq_t req,
   input  logic    intHit,
   input  logic    devAck,
   output logic    busAck,
   output logic    setNxd
);

   typedef enum logic [1:0] {
      stIdle,
      stCount,
      stNxd,
      stAck
   } nxdState_t;

   nxdState_t          state;
   logic [nxdCntW-1:0] cnt;
   logic               extReq;

   // IO page but not the adapter's own window
   assign extReq = req.valid && (req.addr >= ioPageBase) && !intHit;

   ////////////////////////////////////////
   // State machine
   ////////////////////////////////////////

   // Count state plus counter stands in for ten separate states
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         state <= stIdle;
         cnt   <= '0;
      end
      else
      begin
         case (state)
            stIdle:
            begin
               cnt <= '0;
               if (req.valid && intHit)
                  state <= stAck;
               else if (extReq)
                  state <= stCount;
            end
            stCount:
            begin
               if (devAck)
                  state <= stAck;
               else if (cnt == nxdCntW'(nxdCount - 1))
                  state <= stNxd;
               else
                  cnt <= cnt + 1'b1;
            end
            // Hold until the master lets go
            stAck:
               if (!req.valid)
                  state <= stIdle;
            stNxd:
               state <= stIdle;
            default:
               state <= stIdle;
         endcase
      end
   end

   assign busAck = (state == stAck);
   assign setNxd = (state == stNxd);

   assert property (@(posedge clk) disable iff (rst) !(busAck && setNxd))
      else $error("busAck and setNxd together");

   // Timeout is a single cycle pulse
   assert property (@(posedge clk) disable iff (rst) setNxd |=> !setNxd)
      else $error("setNxd longer than one cycle");

endmodule

// ==== rtl/ubaRegPkg.sv ====
/*
 Register side definitions for the adapter's own register window.
 Word selects for the status and maintenance registers, and the
 status word seen either as a raw word or as fields.
*/

package ubaRegPkg;

   ////////////////////////////////////////
   // Register word selects
   ////////////////////////////////////////

   // Address bit 1 picks the word inside the window
   localparam logic srOffset = 1'b0;
   localparam logic mrOffset = 1'b1;

   ////////////////////////////////////////
   // Status register layout
   ////////////////////////////////////////

   // Field view, msb first
   typedef struct packed {
      logic [13:0] spare;   // always reads zero
      logic        intEn;   // interrupt enable, read/write
      logic        nxd;     // sticky timeout flag, write one to clear
   } ubaStatusF_t;

   // Same 16 bits as a plain bus word
   typedef union packed {
      logic [15:0] raw;
      ubaStatusF_t f;
   } ubaStatus_u;

   // Field positions within the raw word
   localparam int srNxdBit   = 0;
   localparam int srIntEnBit = 1;

endpackage

// ==== rtl/ubaRegs.sv ====
/*
 Adapter register window. Decodes the two word window, keeps the
 status and maintenance scratch registers and returns read data
 in the acknowledge cycle. The timeout flag from the state machine
 sets the sticky status bit.
*/

`timescale 1ns/1ps

module ubaRegs
   import ubaBusPkg::*, ubaRegPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  ubaReq_t     req,
   input  logic        busAck,
   input  logic        setNxd,
   output logic        intHit,
   output logic [15:0] regData,
   output ubaStatus_u  status
);

   ubaStatus_u  statusQ;
   ubaStatus_u  wrWord;
   logic [15:0] mrQ;
   logic [15:0] rdMux;
   logic        wordSel;
   logic        access;

   ////////////////////////////////////////
   // Window decode
   ////////////////////////////////////////

   // Match on the upper address bits only
   assign intHit  = req.valid && (req.addr[17:2] == regWinBase[17:2]);
   assign wordSel = req.addr[1];

   // Single access on the edge that raises busAck
   assign access  = intHit && !busAck;

   // Write data taken apart through the status layout
   assign wrWord.raw = req.wdata;

   always_comb
   begin
      case (wordSel)
         srOffset: rdMux = statusQ.raw;
         mrOffset: rdMux = mrQ;
         default:  rdMux = '0;
      endcase
   end

   ////////////////////////////////////////
   // Status and scratch registers
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         statusQ.raw <= '0;
         mrQ         <= '0;
      end
      else
      begin
         if (access && req.write && (wordSel == srOffset))
         begin
            // Write one clears the sticky flag
            if (wrWord.raw[srNxdBit])
               statusQ.f.nxd <= 1'b0;
            statusQ.f.intEn <= wrWord.raw[srIntEnBit];
         end
         if (access && req.write && (wordSel == mrOffset))
            mrQ <= req.wdata;
         // Timeout set beats a clear in the same cycle
         if (setNxd)
            statusQ.f.nxd <= 1'b1;
      end
   end

   // Read data held for the whole ack, zero when idle
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         regData <= '0;
      else if (!req.valid)
         regData <= '0;
      else if (access && !req.write)
         regData <= rdMux;
   end

   assign status = statusQ;

   // New window hit only arrives after the previous ack has ended
   assert property (@(posedge clk) disable iff (rst) $rose(intHit) |-> !busAck)
      else $error("intHit rose during busAck");

endmodule

// ==== rtl/ubaResp.sv ====
/*
 Response combiner. Latches external device read data, merges it
 with register read data, forms the bus response from the state
 machine outputs and registers the interrupt request.
*/

`timescale 1ns/1ps

module ubaResp
   import ubaBusPkg::*, ubaRegPkg::*;
(
   input  logic        clk,
   input  logic        rst,
   input  ubaReq_t     req,
   input  logic        busAck,
   input  logic        setNxd,
   input  logic [15:0] regData,
   input  ubaDevRsp_t  dev,
   input  ubaStatus_u  status,
   output ubaResp_t    rsp,
   output logic        intReq
);

   logic [15:0] devData;

   ////////////////////////////////////////
   // Device data latch
   ////////////////////////////////////////

   // Loads with the ack pulse, cleared once the request ends
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         devData <= '0;
      else if (!req.valid)
         devData <= '0;
      else if (dev.ack)
         devData <= dev.rdata;
   end

   // Only one source is non zero at a time
   assign rsp.ack   = busAck;
   assign rsp.nxd   = setNxd;
   assign rsp.rdata = regData | devData;

   // Interrupt follows the sticky flag when enabled
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         intReq <= 1'b0;
      else
         intReq <= status.f.nxd && status.f.intEn;
   end

   assert property (@(posedge clk) disable iff (rst) !(rsp.ack && rsp.nxd))
      else $error("rsp.ack and rsp.nxd together");

endmodule

// ==== rtl/ubaTop.sv ====
/*
 Top level of the Unibus adapter slave front end. Connects the
 register block, the timeout state machine and the response
 combiner between the master request and the external device.
*/

`timescale 1ns/1ps

module ubaTop
   import ubaBusPkg::*, ubaRegPkg::*;
(
   input  logic       clk,
   input  logic       rst,
   input  ubaReq_t    req,
   input  ubaDevRsp_t dev,
   output ubaResp_t   rsp,
   output logic       intReq
);

   logic        intHit;
   logic        busAck;
   logic        setNxd;
   logic [15:0] regData;
   ubaStatus_u  status;

   // Register window and status
   ubaRegs ubaRegs_i (
      .clk     (clk),
      .rst     (rst),
      .req     (req),
      .busAck  (busAck),
      .setNxd  (setNxd),
      .intHit  (intHit),
      .regData (regData),
      .status  (status)
   );

   // Ack and timeout sequencing
   ubaNxd ubaNxd_i (
      .clk    (clk),
      .rst    (rst),
      .req    (req),
      .intHit (intHit),
      .devAck (dev.ack),
      .busAck (busAck),
      .setNxd (setNxd)
   );

   // Bus response and interrupt
   ubaResp ubaResp_i (
      .clk     (clk),
      .rst     (rst),
      .req     (req),
      .busAck  (busAck),
      .setNxd  (setNxd),
      .regData (regData),
      .dev     (dev),
      .status  (status),
      .rsp     (rsp),
      .intReq  (intReq)
   );

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Build the adapter testbench with Verilator, run it, and check the log
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
   -f flist.f --top-module ubaTb -j 0

# The simulation status is not trusted alone, the log decides
./obj_dir/VubaTb | tee sim.log

if grep -q "^Test passed$" sim.log; then
   echo "Simulation PASS"
   exit 0
else
   echo "Simulation FAIL"
   exit 1
fi

// ==== tests/ubaTb.sv ====
/*
 Table driven testbench for the Unibus adapter slave front end.
 Applies register rows and external device rows, then seeded random
 external reads, against a small device model. Stops at the first
 mismatch.
*/

`timescale 1ns/1ps

module ubaTb
   import ubaBusPkg::*;
();

   // One stimulus row with its expected outcome
   typedef struct packed {
      logic        write;
      logic [17:0] addr;
      logic [15:0] wdata;
      logic [3:0]  delay;     // device ack delay where 15 means never
      logic [15:0] ddata;
      logic        expNxd;
      logic [15:0] expData;
      logic        expInt;
   } stimRow_t;

   logic       clk;
   logic       rst;
   ubaReq_t    req;
   ubaDevRsp_t dev;
   ubaResp_t   rsp;
   logic       intReq;

   stimRow_t   rows[$];
   string      names[$];

   // Device model state
   ubaReq_t     seenReq;
   int          devCnt;
   bit          devAcked;
   logic [3:0]  devDelay;
   logic [15:0] devValue;

   ubaTop ubaTop_i (
      .clk    (clk),
      .rst    (rst),
      .req    (req),
      .dev    (dev),
      .rsp    (rsp),
      .intReq (intReq)
   );

   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   ////////////////////////////////////////
   // Address map helpers
   ////////////////////////////////////////

   // Two words at byte offsets 0 and 2 above the window base
   function automatic bit isWindow(input logic [17:0] addr);
      return (addr >= regWinBase) && (addr <= regWinBase + 18'd3);
   endfunction

   function automatic bit isExternal(input logic [17:0] addr);
      return (addr >= ioPageBase) && !isWindow(addr);
   endfunction

   // Cycles from request to response as counted at sample points
   function automatic int expLatency(input stimRow_t r);
      if (isWindow(r.addr))
         return 1;
      else if (r.delay <= 9)
         return int'(r.delay) + 2;
      else
         return nxdCount + 1;
   endfunction

   ////////////////////////////////////////
   // External device model
   ////////////////////////////////////////

   // Request taken at the edge and answered 1 ns later
   always @(posedge clk)
   begin
      seenReq = req;
      #1;
      dev.ack   = 1'b0;
      dev.rdata = '0;
      if (!seenReq.valid)
      begin
         devCnt   = 0;
         devAcked = 1'b0;
      end
      else if (isExternal(seenReq.addr) && !devAcked)
      begin
         if (devCnt == int'(devDelay))
         begin
            dev.ack   = 1'b1;
            dev.rdata = devValue;
            devAcked  = 1'b1;
         end
         devCnt++;
      end
   end

   ////////////////////////////////////////
   // Tasks
   ////////////////////////////////////////

   task automatic nextCycle();
      @(posedge clk);
      #1;
   endtask

   task automatic reportFailure();
      $display("Test failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic checkValue(input string name, input string what,
                             input logic [31:0] exp, input logic [31:0] act);
      assert (exp === act)
      else
      begin
         $display("ERR %s %s expected %0h actual %0h", name, what, exp, act);
         reportFailure();
      end
   endtask

   task automatic addRow(input string name, input logic write, input logic [17:0] addr,
                         input logic [15:0] wdata, input logic [3:0] delay,
                         input logic [15:0] ddata, input logic expNxd,
                         input logic [15:0] expData, input logic expInt);
      stimRow_t r;
      r = '{write, addr, wdata, delay, ddata, expNxd, expData, expInt};
      rows.push_back(r);
      names.push_back(name);
   endtask

   // Issue one request, wait for ack or nxd, then release and check
   task automatic applyRow(input string name, input stimRow_t r);
      int cycles;
      bit seen;
      devDelay  = r.delay;
      devValue  = r.ddata;
      req.write = r.write;
      req.addr  = r.addr;
      req.wdata = r.wdata;
      req.valid = 1'b1;
      cycles    = 0;
      seen      = 1'b0;
      while (!seen && cycles < 40)
      begin
         nextCycle();
         cycles++;
         if (rsp.ack || rsp.nxd)
            seen = 1'b1;
      end
      assert (seen)
      else
      begin
         $display("No ack or nxd from the DUT within 40 cycles in %s", name);
         reportFailure();
      end
      checkValue(name, "nxd", 32'(r.expNxd), 32'(rsp.nxd));
      checkValue(name, "ack", 32'(!r.expNxd), 32'(rsp.ack));
      checkValue(name, "latency", expLatency(r), cycles);
      checkValue(name, "rdata", 32'(r.expData), 32'(rsp.rdata));
      // Ack is a level while valid stays up
      if (!r.expNxd)
      begin
         nextCycle();
         checkValue(name, "ackHold", 32'd1, 32'(rsp.ack));
      end
      req = '0;
      nextCycle();
      // Nxd was a single pulse and ack follows valid down
      checkValue(name, "ackAfter", 32'd0, 32'(rsp.ack));
      checkValue(name, "nxdAfter", 32'd0, 32'(rsp.nxd));
      nextCycle();
      nextCycle();
      checkValue(name, "intReq", 32'(r.expInt), 32'(intReq));
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial
   begin
      logic [17:0] rndAddr;
      logic [3:0]  rndDelay;
      logic [15:0] rndData;
      void'($urandom(82235));
      rst      = 1'b1;
      req      = '0;
      dev      = '0;
      devDelay = 4'd15;
      devValue = '0;
      devCnt   = 0;
      devAcked = 1'b0;

      // Directed rows
      addRow("rdStatusReset", 0, regWinBase, 0, 15, 0, 0, 16'h0000, 0);
      addRow("wrScratch", 1, regWinBase + 18'd2, 16'hA5C3, 15, 0, 0, 16'h0000, 0);
      addRow("rdScratch", 0, regWinBase + 18'd2, 0, 15, 0, 0, 16'hA5C3, 0);
      addRow("extRead0", 0, 18'o772100, 0, 0, 16'h1234, 0, 16'h1234, 0);
      addRow("extRead9", 0, 18'o777560, 0, 9, 16'hBEEF, 0, 16'hBEEF, 0);
      addRow("extTimeout", 0, 18'o764000, 0, 15, 16'hFFFF, 1, 16'h0000, 0);
      addRow("rdStatusNxd", 0, regWinBase, 0, 15, 0, 0, 16'h0001, 0);
      addRow("wrIntEnClr", 1, regWinBase, 16'h0003, 15, 0, 0, 16'h0000, 0);
      addRow("intTimeout", 1, 18'o766000, 16'h5555, 15, 0, 1, 16'h0000, 1);
      addRow("rdStatusInt", 0, regWinBase, 0, 15, 0, 0, 16'h0003, 1);
      addRow("clrNxd", 1, regWinBase, 16'h0003, 15, 0, 0, 16'h0000, 0);
      addRow("rdStatusClr", 0, regWinBase, 0, 15, 0, 0, 16'h0002, 0);
      addRow("wrIntDis", 1, regWinBase, 16'h0000, 15, 0, 0, 16'h0000, 0);

      // Random external reads at even IO page addresses
      for (int k = 0; k < 8; k++)
      begin
         rndAddr    = ioPageBase + 18'($urandom % 8192);
         rndAddr[0] = 1'b0;
         if (isWindow(rndAddr))
            rndAddr = rndAddr + 18'd4;
         rndDelay = 4'($urandom % 11);
         if (rndDelay == 4'd10)
            rndDelay = 4'd15;
         rndData = 16'($urandom);
         addRow($sformatf("rndRead%0d", k), 0, rndAddr, 0, rndDelay, rndData,
                rndDelay == 4'd15, (rndDelay == 4'd15) ? 16'h0000 : rndData, 0);
      end

      repeat (5) @(posedge clk);
      #1;
      rst = 1'b0;

      // Quiet outputs out of reset
      checkValue("reset", "ack", 32'd0, 32'(rsp.ack));
      checkValue("reset", "nxd", 32'd0, 32'(rsp.nxd));
      checkValue("reset", "intReq", 32'd0, 32'(intReq));

      foreach (rows[i])
         applyRow(names[i], rows[i]);

      $display("Test passed");
      $finish;
   end

endmodule
